//--- rtl/table_load_pkg.sv
`default_nettype none

package table_load_pkg;

  ////////////////////////////////////////////////////////////
  // widths and limits
  ////////////////////////////////////////////////////////////

  // AXI side
  localparam int ADDR_W          = 32;
  localparam int BEAT_W          = 128;
  localparam int BEAT_BYTES      = BEAT_W / 8;
  localparam int BURST_BEATS     = 256;
  localparam int BURST_BYTES     = BURST_BEATS * BEAT_BYTES;
  localparam int MAX_OUTSTANDING = 4;

  // table side, one beat carries one word per column of a half
  localparam int WORD_W        = 32;
  localparam int COLS_PER_BEAT = BEAT_W / WORD_W;
  localparam int NUM_COL       = 2 * COLS_PER_BEAT;
  localparam int TBL_DEPTH     = 16;
  localparam int PC_W          = 12;

  ////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0]                                   addr_t;
  typedef logic [ADDR_W-1:0]                                   xfer_size_t;
  typedef logic [BEAT_W-1:0]                                   beat_t;
  typedef logic [WORD_W-1:0]                                   word_t;
  typedef logic [PC_W-1:0]                                     pc_t;
  typedef logic [$clog2(TBL_DEPTH)-1:0]                        tbl_addr_t;
  typedef logic [NUM_COL-1:0]                                  col_mask_t;
  typedef logic [$clog2(BURST_BEATS)-1:0]                      arlen_t;
  // beats minus one, byte count with the in-beat offset dropped
  typedef logic [ADDR_W-$clog2(BEAT_BYTES)-1:0]                beat_count_t;
  typedef logic [ADDR_W-$clog2(BEAT_BYTES)-$clog2(BURST_BEATS)-1:0] burst_count_t;

  // which half of the columns the loader is filling
  typedef enum logic [1:0] {
    idle,
    low_half,
    high_half
  } load_state_t;

  // burst plan handed to the AR and R side
  typedef struct packed {
    addr_t        base_addr;
    arlen_t       final_arlen;
    burst_count_t bursts_m1;
  } xfer_plan_t;

  // one table write, mask is zero when nothing is written
  typedef struct packed {
    col_mask_t col_mask;
    tbl_addr_t index;
    beat_t     data;
  } table_write_t;

endpackage

`default_nettype wire

//--- rtl/run_control.sv
`timescale 1ns/1ps
`default_nettype none

module run_control (
  input  wire logic                       aclk,
  input  wire logic                       areset,
  input  wire logic                       ctrl_start,
  input  table_load_pkg::addr_t           ctrl_addr_offset,
  input  table_load_pkg::xfer_size_t      ctrl_xfer_size,
  input  wire logic                       done_steady,
  output table_load_pkg::xfer_plan_t      plan,
  output logic                            start,
  output table_load_pkg::word_t           cycle_register
);

  table_load_pkg::addr_t       base_q;
  table_load_pkg::beat_count_t beats_m1_q;
  table_load_pkg::beat_count_t whole_beats;
  logic                        partial_beat;
  logic                        start_d1;

  ////////////////////////////////////////////////////////////
  // request capture
  ////////////////////////////////////////////////////////////

  // full beats in the request, plus one if a tail is left over
  assign whole_beats  = table_load_pkg::beat_count_t'(ctrl_xfer_size / table_load_pkg::BEAT_BYTES);
  assign partial_beat = (ctrl_xfer_size % table_load_pkg::BEAT_BYTES) != 0;

  // a zero byte count is not a valid request
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // align down so no burst crosses a 4 kB page
      base_q     <= ctrl_addr_offset &
                    ~table_load_pkg::addr_t'(table_load_pkg::BURST_BYTES - 1);
      beats_m1_q <= partial_beat ? whole_beats : whole_beats - 1'b1;
    end
  end

  // split the beat count into full bursts and the tail burst
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      plan.base_addr   <= base_q;
      plan.final_arlen <= table_load_pkg::arlen_t'(beats_m1_q);
      plan.bursts_m1   <= table_load_pkg::burst_count_t'(beats_m1_q /
                                                         table_load_pkg::BURST_BEATS);
    end
  end

  // start strobe lines up with the plan, two edges after ctrl_start
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      start    <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      start    <= start_d1;
    end
  end

  ////////////////////////////////////////////////////////////
  // cycle register
  ////////////////////////////////////////////////////////////

  // cleared by a new request, counts steady cycles
  always_ff @(posedge aclk) begin
    if (areset) begin
      cycle_register <= '0;
    end else if (ctrl_start) begin
      cycle_register <= '0;
    end else if (done_steady) begin
      cycle_register <= cycle_register + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/ar_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module ar_issuer (
  input  wire logic                  aclk,
  input  wire logic                  areset,
  input  table_load_pkg::xfer_plan_t plan,
  input  wire logic                  start,
  input  wire logic                  burst_done,
  input  wire logic                  arready,
  output logic                       arvalid,
  output table_load_pkg::addr_t      araddr,
  output table_load_pkg::arlen_t     arlen
);

  logic                                                  arxfer;
  logic                                                  idle;
  logic                                                  final_burst;
  logic                                                  stall;
  table_load_pkg::burst_count_t                          to_go;
  logic [$clog2(table_load_pkg::MAX_OUTSTANDING+1)-1:0] vacancy;

  assign arxfer      = arvalid & arready;
  // countdown at zero means the burst on the bus is the last one
  assign final_burst = (to_go == '0);
  // no free slot, hold off until a burst completes
  assign stall       = (vacancy == '0);

  ////////////////////////////////////////////////////////////
  // issue control
  ////////////////////////////////////////////////////////////

  // idle until a start, back to idle once the last address is taken
  always_ff @(posedge aclk) begin
    if (areset) begin
      idle <= 1'b1;
    end else if (start) begin
      idle <= 1'b0;
    end else if (arxfer && final_burst) begin
      idle <= 1'b1;
    end
  end

  // bursts still to issue, minus one
  always_ff @(posedge aclk) begin
    if (areset) begin
      to_go <= '0;
    end else if (start) begin
      to_go <= plan.bursts_m1;
    end else if (arxfer) begin
      to_go <= to_go - 1'b1;
    end
  end

  // free slots for outstanding bursts
  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= $bits(vacancy)'(table_load_pkg::MAX_OUTSTANDING);
    end else begin
      case ({burst_done, arxfer})
        2'b10:   vacancy <= vacancy + 1'b1;
        2'b01:   vacancy <= vacancy - 1'b1;
        default: vacancy <= vacancy;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // AR channel
  ////////////////////////////////////////////////////////////

  // valid holds until accepted, then drops for at least one cycle
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid <= 1'b0;
    end else if (arvalid) begin
      if (arready) begin
        arvalid <= 1'b0;
      end
    end else if (!idle && !stall) begin
      arvalid <= 1'b1;
    end
  end

  // next page after each accepted address
  always_ff @(posedge aclk) begin
    if (start) begin
      araddr <= plan.base_addr;
    end else if (arxfer) begin
      araddr <= araddr + table_load_pkg::addr_t'(table_load_pkg::BURST_BYTES);
    end
  end

  // full length except for the tail burst
  assign arlen = final_burst ? plan.final_arlen
                             : table_load_pkg::arlen_t'(table_load_pkg::BURST_BEATS - 1);

endmodule

`default_nettype wire

//--- rtl/r_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module r_tracker (
  input  wire logic                  aclk,
  input  wire logic                  areset,
  input  table_load_pkg::xfer_plan_t plan,
  input  wire logic                  start,
  input  wire logic                  rvalid,
  input  wire logic                  rlast,
  output logic                       burst_done,
  output logic                       ctrl_done
);

  table_load_pkg::burst_count_t remaining;
  logic                         final_burst;

  // with rready tied high every rlast beat ends a burst
  assign burst_done  = rvalid & rlast;
  assign final_burst = (remaining == '0);

  // bursts still to complete minus one
  always_ff @(posedge aclk) begin
    if (areset) begin
      remaining <= '0;
    end else if (start) begin
      remaining <= plan.bursts_m1;
    end else if (burst_done && !final_burst) begin
      remaining <= remaining - 1'b1;
    end
  end

  // single cycle pulse after the last rlast
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= burst_done & final_burst;
    end
  end

endmodule

`default_nettype wire

//--- rtl/table_loader.sv
`timescale 1ns/1ps
`default_nettype none

module table_loader (
  input  wire logic                    aclk,
  input  wire logic                    areset,
  input  wire logic                    rvalid,
  input  table_load_pkg::beat_t        rdata,
  input  wire logic                    ctrl_done,
  output table_load_pkg::table_write_t wr
);

  table_load_pkg::load_state_t state;
  table_load_pkg::load_state_t state_next;
  table_load_pkg::tbl_addr_t   index;
  table_load_pkg::col_mask_t   low_mask;
  table_load_pkg::col_mask_t   high_mask;
  table_load_pkg::col_mask_t   half_mask;
  logic                        wrap;

  // one column per word lane in each half
  assign low_mask  = table_load_pkg::col_mask_t'((1 << table_load_pkg::COLS_PER_BEAT) - 1);
  assign high_mask = low_mask << table_load_pkg::COLS_PER_BEAT;

  // last entry of the table taken this cycle
  assign wrap = rvalid && (index == table_load_pkg::tbl_addr_t'(table_load_pkg::TBL_DEPTH - 1));

  ////////////////////////////////////////////////////////////
  // write index
  ////////////////////////////////////////////////////////////

  // wraps by width after the last entry
  always_ff @(posedge aclk) begin
    if (areset) begin
      index <= '0;
    end else if (rvalid) begin
      index <= index + 1'b1;
    end else if (ctrl_done) begin
      index <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // half select FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      table_load_pkg::idle:      if (rvalid) state_next = table_load_pkg::low_half;
      table_load_pkg::low_half:  if (wrap) state_next = table_load_pkg::high_half;
      table_load_pkg::high_half: state_next = table_load_pkg::high_half;
      default:                   state_next = table_load_pkg::idle;
    endcase
    // end of load from either half
    if (ctrl_done) begin
      state_next = table_load_pkg::idle;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= table_load_pkg::idle;
    end else begin
      state <= state_next;
    end
  end

  // the first beat arrives while still idle and goes to the low half
  assign half_mask = (state == table_load_pkg::high_half) ? high_mask : low_mask;

  // write goes out on the same edge as the beat
  assign wr.col_mask = rvalid ? half_mask : '0;
  assign wr.index    = index;
  assign wr.data     = rdata;

endmodule

`default_nettype wire

//--- rtl/instr_table_bank.sv
`timescale 1ns/1ps
`default_nettype none

module instr_table_bank (
  input  wire logic                                                aclk,
  input  wire logic                                                areset,
  input  table_load_pkg::table_write_t                             wr,
  input  table_load_pkg::col_mask_t                                clken_pc,
  input  table_load_pkg::col_mask_t                                load_pc,
  input  table_load_pkg::col_mask_t                                incr_pc,
  input  table_load_pkg::pc_t [table_load_pkg::NUM_COL-1:0]        load_value_pc,
  output table_load_pkg::word_t [table_load_pkg::NUM_COL-1:0]      instr
);

  ////////////////////////////////////////////////////////////
  // one table and one PC per column
  ////////////////////////////////////////////////////////////

  for (genvar c = 0; c < table_load_pkg::NUM_COL; c++) begin : g_col
    table_load_pkg::word_t     mem [table_load_pkg::TBL_DEPTH];
    table_load_pkg::pc_t       pc;
    table_load_pkg::tbl_addr_t rd_index;
    table_load_pkg::word_t     lane;
    table_load_pkg::word_t     rd_q;

    // both halves share the same four word lanes
    assign lane = wr.data[(c % table_load_pkg::COLS_PER_BEAT)*table_load_pkg::WORD_W +:
                          table_load_pkg::WORD_W];

    always_ff @(posedge aclk) begin
      if (wr.col_mask[c]) begin
        mem[wr.index] <= lane;
      end
    end

    // load wins over increment, both need the clock enable
    always_ff @(posedge aclk) begin
      if (areset) begin
        pc <= '0;
      end else if (clken_pc[c]) begin
        if (load_pc[c]) begin
          pc <= load_value_pc[c];
        end else if (incr_pc[c]) begin
          pc <= pc + 1'b1;
        end
      end
    end

    // table is addressed by the low PC bits only
    assign rd_index = table_load_pkg::tbl_addr_t'(pc);

    // registered read, new entry one edge after the PC moves
    always_ff @(posedge aclk) begin
      rd_q <= mem[rd_index];
    end

    assign instr[c] = rd_q;
  end

endmodule

`default_nettype wire

//--- rtl/table_load_top.sv
`timescale 1ns/1ps
`default_nettype none

module table_load_top (
  input  wire logic                                           aclk,
  input  wire logic                                           areset,
  // control
  input  wire logic                                           ctrl_start,
  input  table_load_pkg::addr_t                               ctrl_addr_offset,
  input  table_load_pkg::xfer_size_t                          ctrl_xfer_size,
  output logic                                                ctrl_done,
  input  wire logic                                           done_steady,
  output table_load_pkg::word_t                               cycle_register,
  // AXI4 read address channel
  output logic                                                arvalid,
  input  wire logic                                           arready,
  output table_load_pkg::addr_t                               araddr,
  output table_load_pkg::arlen_t                              arlen,
  // AXI4 read data channel
  input  wire logic                                           rvalid,
  output logic                                                rready,
  input  table_load_pkg::beat_t                               rdata,
  input  wire logic                                           rlast,
  // per column PC controls
  input  table_load_pkg::col_mask_t                           clken_pc,
  input  table_load_pkg::col_mask_t                           load_pc,
  input  table_load_pkg::col_mask_t                           incr_pc,
  input  table_load_pkg::pc_t [table_load_pkg::NUM_COL-1:0]   load_value_pc,
  output table_load_pkg::word_t [table_load_pkg::NUM_COL-1:0] instr
);

  table_load_pkg::xfer_plan_t   plan;
  table_load_pkg::table_write_t wr;
  logic                         start;
  logic                         burst_done;

  // every beat lands in a table write, never back-pressured
  assign rready = 1'b1;

  ////////////////////////////////////////////////////////////
  // request and AXI read side
  ////////////////////////////////////////////////////////////

  run_control u_run_control (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size   (ctrl_xfer_size),
    .done_steady      (done_steady),
    .plan             (plan),
    .start            (start),
    .cycle_register   (cycle_register)
  );

  ar_issuer u_ar_issuer (
    .aclk       (aclk),
    .areset     (areset),
    .plan       (plan),
    .start      (start),
    .burst_done (burst_done),
    .arready    (arready),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .arlen      (arlen)
  );

  r_tracker u_r_tracker (
    .aclk       (aclk),
    .areset     (areset),
    .plan       (plan),
    .start      (start),
    .rvalid     (rvalid),
    .rlast      (rlast),
    .burst_done (burst_done),
    .ctrl_done  (ctrl_done)
  );

  ////////////////////////////////////////////////////////////
  // table fill and readout
  ////////////////////////////////////////////////////////////

  table_loader u_table_loader (
    .aclk      (aclk),
    .areset    (areset),
    .rvalid    (rvalid),
    .rdata     (rdata),
    .ctrl_done (ctrl_done),
    .wr        (wr)
  );

  instr_table_bank u_instr_table_bank (
    .aclk          (aclk),
    .areset        (areset),
    .wr            (wr),
    .clken_pc      (clken_pc),
    .load_pc       (load_pc),
    .incr_pc       (incr_pc),
    .load_value_pc (load_value_pc),
    .instr         (instr)
  );

endmodule

`default_nettype wire

//--- tb/table_load_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module table_load_assertions (
  input wire logic                    aclk,
  input wire logic                    areset,
  input wire logic                    arvalid,
  input wire logic                    arready,
  input table_load_pkg::addr_t        araddr,
  input table_load_pkg::arlen_t       arlen,
  input wire logic                    ctrl_done,
  input wire logic                    rready
);

  ////////////////////////////////////////////////////////////
  // AXI read address channel
  ////////////////////////////////////////////////////////////

  // a waiting address may not move or be withdrawn
  property ar_held_until_ready;
    @(posedge aclk) disable iff (areset)
      arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen);
  endproperty

  assert property (ar_held_until_ready)
    else $error("araddr or arlen changed, or arvalid dropped, before arready");

  ////////////////////////////////////////////////////////////
  // done pulse and data ready
  ////////////////////////////////////////////////////////////

  // done is a single cycle pulse
  assert property (@(posedge aclk) disable iff (areset) ctrl_done |=> !ctrl_done)
    else $error("ctrl_done high on two consecutive cycles");

  // read data is never back-pressured
  assert property (@(posedge aclk) !areset |-> rready)
    else $error("rready low outside reset");

endmodule

`default_nettype wire

//--- tb/table_load_tb.sv
`timescale 1ns/1ps
`default_nettype none

module table_load_tb;

  logic                                                aclk;
  logic                                                areset;
  logic                                                ctrl_start;
  table_load_pkg::addr_t                               ctrl_addr_offset;
  table_load_pkg::xfer_size_t                          ctrl_xfer_size;
  logic                                                ctrl_done;
  logic                                                done_steady;
  table_load_pkg::word_t                               cycle_register;
  logic                                                arvalid;
  logic                                                arready;
  table_load_pkg::addr_t                               araddr;
  table_load_pkg::arlen_t                              arlen;
  logic                                                rvalid;
  logic                                                rready;
  table_load_pkg::beat_t                               rdata;
  logic                                                rlast;
  table_load_pkg::col_mask_t                           clken_pc;
  table_load_pkg::col_mask_t                           load_pc;
  table_load_pkg::col_mask_t                           incr_pc;
  table_load_pkg::pc_t [table_load_pkg::NUM_COL-1:0]   load_value_pc;
  table_load_pkg::word_t [table_load_pkg::NUM_COL-1:0] instr;

  // one row per test with name, start address, bytes, R delay and done_steady edges,
  // then the expected bursts, page base and arlen of the last burst
  string names [5] = '{"short_load", "long_xfer", "limit_xfer", "one_beat", "full_page"};
  table_load_pkg::addr_t addrs [5] = '{32'h0001_2345, 32'h0040_0a10, 32'h1234_5678,
                                       32'h0000_0fff, 32'h8000_3000};
  int sizes    [5] = '{500, 9000, 24000, 1, 4096};
  int delays   [5] = '{3, 40, 48, 0, 5};
  int steadies [5] = '{7, 13, 0, 20, 2};
  int bursts   [5] = '{1, 3, 6, 1, 1};
  table_load_pkg::addr_t bases [5] = '{32'h0001_2000, 32'h0040_0000, 32'h1234_5000,
                                       32'h0000_0000, 32'h8000_3000};
  table_load_pkg::arlen_t last_lens [5] = '{8'd31, 8'd50, 8'd219, 8'd0, 8'd255};

  int                     cycle;
  int                     cycle_limit = 1000000;
  int                     checks;
  int                     errors;
  int                     faults;
  string                  test_name = "reset";
  logic [31:0]            rng = 32'd68373;
  int                     r_delay;
  // slave model state for addresses seen and bursts waiting for data
  table_load_pkg::addr_t  ar_addr_log [$];
  table_load_pkg::arlen_t ar_len_log [$];
  table_load_pkg::addr_t  addr_q [$];
  table_load_pkg::arlen_t len_q [$];
  int                     due_q [$];
  int                     outstanding;
  bit                     r_active;
  table_load_pkg::addr_t  r_addr;
  table_load_pkg::arlen_t r_len;
  int                     r_beat;
  int                     beat_n;
  int                     last_beat_cyc;
  int                     done_count;
  int                     done_cyc;
  int                     col;
  // expected table contents
  table_load_pkg::word_t  ref_tbl [table_load_pkg::NUM_COL][table_load_pkg::TBL_DEPTH];

  table_load_top u_table_load_top (.*);

  bind table_load_top table_load_assertions u_table_load_assertions (
    .aclk      (aclk),
    .areset    (areset),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .arlen     (arlen),
    .ctrl_done (ctrl_done),
    .rready    (rready)
  );

  ////////////////////////////////////////////////////////////
  // clock, cycle count and timeout
  ////////////////////////////////////////////////////////////

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycle++;
    if (cycle > cycle_limit) begin
      $display("timeout after %0d cycles in test %s", cycle_limit, test_name);
      print_counts();
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // memory pattern where every word depends on its full byte address
  function automatic table_load_pkg::beat_t beat_pattern(input table_load_pkg::addr_t addr);
    table_load_pkg::beat_t b;
    table_load_pkg::addr_t a;
    for (int k = 0; k < table_load_pkg::COLS_PER_BEAT; k++) begin
      a = addr + table_load_pkg::addr_t'(4 * k);
      b[k*table_load_pkg::WORD_W +: table_load_pkg::WORD_W] = (a * 32'h9e37_79b1) ^
                                                                {a[15:0], a[31:16]};
    end
    return b;
  endfunction

  ////////////////////////////////////////////////////////////
  // AXI slave model
  ////////////////////////////////////////////////////////////

  // values sampled at the falling edge are the ones taken at the next rising edge
  always begin
    @(negedge aclk);
    if (arvalid && arready) begin
      ar_addr_log.push_back(araddr);
      ar_len_log.push_back(arlen);
      addr_q.push_back(araddr);
      len_q.push_back(arlen);
      due_q.push_back(cycle + r_delay);
      outstanding++;
    end
    if (rvalid) begin
      // the first 16 beats go to columns 0-3 and the rest to columns 4-7
      for (int c = 0; c < table_load_pkg::COLS_PER_BEAT; c++) begin
        col = (beat_n < table_load_pkg::TBL_DEPTH) ? c : c + table_load_pkg::COLS_PER_BEAT;
        ref_tbl[col][beat_n % table_load_pkg::TBL_DEPTH] =
          rdata[c*table_load_pkg::WORD_W +: table_load_pkg::WORD_W];
      end
      beat_n++;
      last_beat_cyc = cycle;
      if (rlast) begin
        outstanding--;
        r_active = 1'b0;
      end else begin
        r_addr = r_addr + table_load_pkg::addr_t'(table_load_pkg::BEAT_BYTES);
        r_beat++;
      end
    end
    if (outstanding > table_load_pkg::MAX_OUTSTANDING) begin
      report_fault($sformatf("%0d bursts outstanding, more than allowed", outstanding));
    end
    if (ctrl_done) begin
      done_count++;
      done_cyc = cycle;
    end
    @(posedge aclk);
    #2;
    rng = xorshift(rng);
    arready = (rng[1:0] != 2'b00);
    // next burst starts once its delay has run out and bursts return in order
    if (!r_active && due_q.size() != 0 && cycle >= due_q[0]) begin
      r_active = 1'b1;
      r_addr = addr_q.pop_front();
      r_len = len_q.pop_front();
      void'(due_q.pop_front());
      r_beat = 0;
    end
    rvalid = r_active;
    rdata = beat_pattern(r_addr);
    rlast = r_active && (r_beat == int'(r_len));
  end

  ////////////////////////////////////////////////////////////
  // compare and report
  ////////////////////////////////////////////////////////////

  task automatic addr_compare(input string label, input table_load_pkg::addr_t exp,
                              input table_load_pkg::addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %h, actual %h", test_name, label, exp, act);
    end
  endtask

  task automatic arlen_compare(input string label, input table_load_pkg::arlen_t exp,
                               input table_load_pkg::arlen_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %0d, actual %0d", test_name, label, exp, act);
    end
  endtask

  task automatic word_compare(input string label, input table_load_pkg::word_t exp,
                              input table_load_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %h, actual %h", test_name, label, exp, act);
    end
  endtask

  task automatic flag_compare(input string label, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %b, actual %b", test_name, label, exp, act);
    end
  endtask

  task automatic report_fault(input string msg);
    faults++;
    $display("test %s failed: %s", test_name, msg);
  endtask

  task automatic print_counts();
    $display("checks %0d, value errors %0d, other failures %0d", checks, errors, faults);
  endtask

  task automatic next_cycle();
    @(posedge aclk);
    #2;
  endtask

  ////////////////////////////////////////////////////////////
  // table and PC checks
  ////////////////////////////////////////////////////////////

  // load every index into all PCs with upper PC bits that must not matter
  task automatic verify_tables();
    for (int i = 0; i < table_load_pkg::TBL_DEPTH; i++) begin
      clken_pc = '1;
      load_pc = '1;
      for (int c = 0; c < table_load_pkg::NUM_COL; c++) begin
        load_value_pc[c] = table_load_pkg::pc_t'(i + table_load_pkg::TBL_DEPTH * (c + 1));
      end
      next_cycle();
      clken_pc = '0;
      load_pc = '0;
      next_cycle();
      for (int c = 0; c < table_load_pkg::NUM_COL; c++) begin
        word_compare($sformatf("col %0d entry %0d", c, i), ref_tbl[c][i], instr[c]);
      end
    end
  endtask

  task automatic exercise_pc_enables();
    clken_pc = '1;
    load_pc = '1;
    load_value_pc = '0;
    next_cycle();
    load_pc = '0;
    // single increments walk through the table and wrap
    for (int k = 1; k <= table_load_pkg::TBL_DEPTH; k++) begin
      incr_pc = '1;
      next_cycle();
      incr_pc = '0;
      next_cycle();
      for (int c = 0; c < table_load_pkg::NUM_COL; c++) begin
        word_compare($sformatf("instr col %0d after increment %0d", c, k),
                     ref_tbl[c][k % table_load_pkg::TBL_DEPTH], instr[c]);
      end
    end
    // with the enable low both load and increment are ignored
    clken_pc = '0;
    load_pc = '1;
    incr_pc = '1;
    for (int c = 0; c < table_load_pkg::NUM_COL; c++) begin
      load_value_pc[c] = table_load_pkg::pc_t'(5 + c);
    end
    repeat (2) next_cycle();
    load_pc = '0;
    incr_pc = '0;
    for (int c = 0; c < table_load_pkg::NUM_COL; c++) begin
      word_compare($sformatf("instr col %0d with clken low", c), ref_tbl[c][0], instr[c]);
    end
    // one enabled step moves on from the held PC
    clken_pc = '1;
    incr_pc = '1;
    next_cycle();
    clken_pc = '0;
    incr_pc = '0;
    next_cycle();
    for (int c = 0; c < table_load_pkg::NUM_COL; c++) begin
      word_compare($sformatf("instr col %0d after held PC", c), ref_tbl[c][1], instr[c]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // one row of the stimulus table
  ////////////////////////////////////////////////////////////

  task automatic run_test(input int t);
    int exp_beats;
    exp_beats = (sizes[t] + table_load_pkg::BEAT_BYTES - 1) / table_load_pkg::BEAT_BYTES;
    test_name = names[t];
    r_delay = delays[t];
    beat_n = 0;
    done_count = 0;
    ar_addr_log.delete();
    ar_len_log.delete();
    ctrl_addr_offset = addrs[t];
    ctrl_xfer_size = table_load_pkg::xfer_size_t'(sizes[t]);
    ctrl_start = 1'b1;
    next_cycle();
    ctrl_start = 1'b0;
    next_cycle();
    word_compare("cycle register after start", '0, cycle_register);
    while (done_count == 0) begin
      next_cycle();
    end
    repeat (3) next_cycle();
    if (done_count != 1) begin
      report_fault($sformatf("ctrl_done pulsed %0d times instead of once", done_count));
    end else if (done_cyc != last_beat_cyc + 1) begin
      report_fault("ctrl_done did not follow the last data beat by one cycle");
    end
    if (beat_n != exp_beats) begin
      report_fault($sformatf("%0d data beats returned, %0d expected", beat_n, exp_beats));
    end
    if (ar_addr_log.size() != bursts[t]) begin
      report_fault($sformatf("%0d bursts issued, %0d expected", ar_addr_log.size(), bursts[t]));
    end else begin
      for (int i = 0; i < bursts[t]; i++) begin
        addr_compare($sformatf("araddr of burst %0d", i),
                     bases[t] + table_load_pkg::addr_t'(i * table_load_pkg::BURST_BYTES),
                     ar_addr_log[i]);
        arlen_compare($sformatf("arlen of burst %0d", i),
                      (i == bursts[t] - 1) ? last_lens[t] :
                      table_load_pkg::arlen_t'(table_load_pkg::BURST_BEATS - 1),
                      ar_len_log[i]);
      end
    end
    verify_tables();
    exercise_pc_enables();
    done_steady = 1'b1;
    repeat (steadies[t]) next_cycle();
    done_steady = 1'b0;
    word_compare("cycle register", table_load_pkg::word_t'(steadies[t]), cycle_register);
  endtask

  initial begin
    int total;
    areset = 1'b1;
    ctrl_start = 1'b0;
    ctrl_addr_offset = '0;
    ctrl_xfer_size = '0;
    done_steady = 1'b0;
    arready = 1'b0;
    rvalid = 1'b0;
    rdata = '0;
    rlast = 1'b0;
    clken_pc = '0;
    load_pc = '0;
    incr_pc = '0;
    load_value_pc = '0;
    r_active = 1'b0;
    r_addr = '0;
    // every beat plus headroom per test for latency and readout
    total = 20;
    for (int t = 0; t < 5; t++) begin
      total += (sizes[t] + table_load_pkg::BEAT_BYTES - 1) / table_load_pkg::BEAT_BYTES +
               200 + delays[t];
    end
    cycle_limit = total;
    repeat (3) @(posedge aclk);
    #2;
    areset = 1'b0;
    flag_compare("arvalid after reset", 1'b0, arvalid);
    flag_compare("ctrl_done after reset", 1'b0, ctrl_done);
    flag_compare("rready after reset", 1'b1, rready);
    word_compare("cycle register after reset", '0, cycle_register);
    for (int t = 0; t < 5; t++) begin
      run_test(t);
    end
    print_counts();
    if (errors == 0 && faults == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
rtl/table_load_pkg.sv
rtl/run_control.sv
rtl/ar_issuer.sv
rtl/r_tracker.sv
rtl/table_loader.sv
rtl/instr_table_bank.sv
rtl/table_load_top.sv
tb/table_load_assertions.sv
tb/table_load_tb.sv

//--- run.sh
#!/bin/sh
# build the table loader testbench with Verilator and run it
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module table_load_tb \
  -f list.f -o table_load_sim > build.log 2>&1 &&
  ./obj_dir/table_load_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -qx "STATUS: PASS" sim.log && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
